// ==== Bender.yml ====
package:
  name: dcache

sources:
  - rtl/cache_pkg.sv
  - rtl/sram_sp.sv
  - rtl/tagv_array.sv
  - rtl/data_array.sv
  - rtl/meta_array.sv
  - rtl/cache_ctrl.sv
  - rtl/cache_top.sv
  - target: test
    files:
      - verif/mem_model.sv
      - verif/tb_cache.sv

// ==== filelist.f ====
rtl/cache_pkg.sv
rtl/sram_sp.sv
rtl/tagv_array.sv
rtl/data_array.sv
rtl/meta_array.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verif/mem_model.sv
verif/tb_cache.sv

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                           clk,
    input  logic                           resetn,
    // cpu side
    input  logic                           valid,
    input  cache_pkg::cpu_req_t            req,
    output logic                           addr_ok,
    output logic                           data_ok,
    output logic [cache_pkg::WORD_W-1:0]   rdata,
    // memory side
    output logic                           rd_req,
    output cache_pkg::mem_rd_req_t         rd_line,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  logic [cache_pkg::WORD_W-1:0]   ret_data,
    output logic                           wr_req,
    output cache_pkg::mem_wr_req_t         wr_line,
    input  logic                           wr_rdy,
    // arrays
    output logic [cache_pkg::INDEX_W-1:0]  arr_index,
    output logic                           arr_rd_en,
    output logic [cache_pkg::NUM_WAYS-1:0] tag_we,
    input  logic [cache_pkg::NUM_WAYS-1:0] hit_way,
    input  logic [cache_pkg::TAG_W-1:0]    victim_tag,
    output cache_pkg::wbuf_t               wbuf,
    output logic                           wbuf_we,
    output logic                           refill_we,
    output logic [cache_pkg::BANK_W-1:0]   refill_cnt,
    output cache_pkg::cpu_req_t            req_buf,
    input  logic [cache_pkg::WORD_W-1:0]   hit_word,
    input  logic [cache_pkg::LINE_W-1:0]   victim_line,
    output logic                           refill_done,
    output logic                           hit_update,
    input  logic                           victim_dirty,
    input  logic [cache_pkg::WAY_W-1:0]    replace_way
);
    import cache_pkg::*;

    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } state_t;

    typedef enum logic [1:0] {
        WR_IDLE  = 2'b01,
        WR_WRITE = 2'b10
    } wr_state_t;

    state_t            state;
    state_t            state_nxt;
    wr_state_t         wr_state;
    wr_state_t         wr_state_nxt;
    logic              cache_hit;
    logic              hit_write;
    logic              conflict;
    logic              accept;
    logic              victim_rdy;   // victim line re-read has settled
    logic [BANK_W-1:0] req_bank;
    logic [BANK_W-1:0] buf_bank;

    assign req_bank  = req.offset[OFFSET_W-1:2];
    assign buf_bank  = req_buf.offset[OFFSET_W-1:2];
    assign cache_hit = |hit_way;
    assign hit_write = state == LOOKUP && cache_hit && req_buf.op;
    assign wbuf_we   = wr_state == WR_WRITE;

    // a read of the store's word would miss the new bytes; a bank under
    // write is also busy at the store's index and cannot serve other sets
    assign conflict = !req.op
        && ((hit_write && req.index == req_buf.index && req_bank == buf_bank)
            || (wbuf_we && req_bank == wbuf.bank));

    assign addr_ok = (state == IDLE || (state == LOOKUP && cache_hit)) && !conflict;
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= IDLE;
            wr_state <= WR_IDLE;
        end else begin
            state    <= state_nxt;
            wr_state <= wr_state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) state_nxt = LOOKUP;
            end
            LOOKUP: begin
                if (cache_hit) begin
                    state_nxt = accept ? LOOKUP : IDLE;   // hits pipeline
                end else begin
                    state_nxt = victim_dirty ? MISS : REPLACE;
                end
            end
            MISS: begin
                if (wr_req && wr_rdy) state_nxt = REPLACE;
            end
            REPLACE: begin
                if (rd_rdy) state_nxt = REFILL;
            end
            REFILL: begin
                if (ret_valid && ret_last) state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_comb begin
        case (wr_state)
            WR_IDLE:  wr_state_nxt = hit_write ? WR_WRITE : WR_IDLE;
            WR_WRITE: wr_state_nxt = hit_write ? WR_WRITE : WR_IDLE;   // back-to-back stores
            default:  wr_state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf <= req;
        end
        if (hit_write) begin
            wbuf.way   <= hit_way[1];
            wbuf.index <= req_buf.index;
            wbuf.bank  <= buf_bank;
            wbuf.wstrb <= req_buf.wstrb;
            wbuf.wdata <= req_buf.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_cnt <= '0;
            victim_rdy <= 1'b0;
        end else begin
            victim_rdy <= state == MISS;
            if (state == REFILL && ret_valid) begin
                refill_cnt <= ret_last ? '0 : refill_cnt + 1'b1;
            end
        end
    end

    // miss path keeps reading the buffered set for the victim line
    assign arr_index = accept ? req.index : req_buf.index;
    assign arr_rd_en = accept || (state == LOOKUP && !cache_hit) || state == MISS;

    assign hit_update  = state == LOOKUP && cache_hit;
    assign refill_we   = state == REFILL && ret_valid;
    assign refill_done = refill_we && ret_last;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_we[w] = refill_done && replace_way == WAY_W'(w);
        end
    end

    assign data_ok = (state == LOOKUP && (cache_hit || req_buf.op))
                     || (refill_we && !req_buf.op && refill_cnt == buf_bank);
    assign rdata   = (state == REFILL) ? ret_data : hit_word;

    assign rd_req       = state == REPLACE;
    assign rd_line.addr = {req_buf.tag, req_buf.index, {OFFSET_W{1'b0}}};

    assign wr_req       = state == MISS && victim_rdy;
    assign wr_line.addr = {victim_tag, req_buf.index, {OFFSET_W{1'b0}}};
    assign wr_line.data = victim_line;

    // victim line is re-read from the rams every MISS cycle
    a_wr_line_hold : assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_line));

    a_rd_line_hold : assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_line));

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // geometry
    localparam int NUM_WAYS  = 2;
    localparam int NUM_SETS  = 256;
    localparam int NUM_BANKS = 4;   // words per line
    localparam int TAG_W     = 20;
    localparam int INDEX_W   = 8;
    localparam int OFFSET_W  = 4;

    localparam int WAY_W  = $clog2(NUM_WAYS);
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;
    localparam int LINE_W = NUM_BANKS * WORD_W;
    localparam int ADDR_W = TAG_W + INDEX_W + OFFSET_W;

    typedef struct packed {
        logic                op;      // 1 = store
        logic [INDEX_W-1:0]  index;
        logic [TAG_W-1:0]    tag;
        logic [OFFSET_W-1:0] offset;
        logic [STRB_W-1:0]   wstrb;
        logic [WORD_W-1:0]   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tagv_t;

    typedef struct packed {
        logic [WAY_W-1:0]   way;
        logic [INDEX_W-1:0] index;
        logic [BANK_W-1:0]  bank;
        logic [STRB_W-1:0]  wstrb;
        logic [WORD_W-1:0]  wdata;
    } wbuf_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // always line aligned
    } mem_rd_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] data;   // bank 0 in the low word
    } mem_wr_req_t;

endpackage

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
    input  logic                          clk,
    input  logic                          resetn,
    // cpu side
    input  logic                          valid,
    input  cache_pkg::cpu_req_t           req,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [cache_pkg::WORD_W-1:0]  rdata,
    // memory side
    output logic                          rd_req,
    output cache_pkg::mem_rd_req_t        rd_line,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  logic                          ret_last,
    input  logic [cache_pkg::WORD_W-1:0]  ret_data,
    output logic                          wr_req,
    output cache_pkg::mem_wr_req_t        wr_line,
    input  logic                          wr_rdy
);
    import cache_pkg::*;

    logic [INDEX_W-1:0]  arr_index;
    logic                arr_rd_en;
    logic [NUM_WAYS-1:0] tag_we;
    logic [NUM_WAYS-1:0] hit_way;
    logic [TAG_W-1:0]    victim_tag;
    wbuf_t               wbuf;
    logic                wbuf_we;
    logic                refill_we;
    logic [BANK_W-1:0]   refill_cnt;
    cpu_req_t            req_buf;
    logic [WORD_W-1:0]   hit_word;
    logic [LINE_W-1:0]   victim_line;
    logic                refill_done;
    logic                hit_update;
    logic                victim_dirty;
    logic [WAY_W-1:0]    replace_way;

    cache_ctrl i_cache_ctrl (.*);

    tagv_array i_tagv_array (
        .clk, .resetn,
        .addr       (arr_index),
        .rd_en      (arr_rd_en),
        .we         (tag_we),
        .wtag       (req_buf.tag),
        .cmp_tag    (req_buf.tag),
        .victim_way (replace_way),
        .hit_way, .victim_tag
    );

    data_array i_data_array (
        .clk,
        .addr        (arr_index),
        .rd_en       (arr_rd_en),
        .wbuf, .wbuf_we, .refill_we,
        .refill_bank (refill_cnt),
        .refill_way  (replace_way),
        .refill_word (ret_data),
        .req         (req_buf),
        .hit_way, .hit_word,
        .victim_way  (replace_way),
        .victim_line
    );

    meta_array i_meta_array (
        .clk, .resetn,
        .index        (req_buf.index),
        .set_dirty    (wbuf_we),
        .dirty_way    (wbuf.way),
        .dirty_index  (wbuf.index),
        .refill_done,
        .refill_dirty (req_buf.op),
        .hit_update, .hit_way, .victim_dirty, .replace_way
    );

endmodule

// ==== rtl/data_array.sv ====
`timescale 1ns/1ps

module data_array (
    input  logic                           clk,
    input  logic [cache_pkg::INDEX_W-1:0]  addr,
    input  logic                           rd_en,
    input  cache_pkg::wbuf_t               wbuf,
    input  logic                           wbuf_we,
    input  logic                           refill_we,
    input  logic [cache_pkg::BANK_W-1:0]   refill_bank,
    input  logic [cache_pkg::WAY_W-1:0]    refill_way,
    input  logic [cache_pkg::WORD_W-1:0]   refill_word,
    input  cache_pkg::cpu_req_t            req,
    input  logic [cache_pkg::NUM_WAYS-1:0] hit_way,
    output logic [cache_pkg::WORD_W-1:0]   hit_word,
    input  logic [cache_pkg::WAY_W-1:0]    victim_way,
    output logic [cache_pkg::LINE_W-1:0]   victim_line
);
    import cache_pkg::*;

    logic [WORD_W-1:0]                  bank_rdata [NUM_WAYS][NUM_BANKS];
    logic [WORD_W-1:0]                  fill_word [NUM_BANKS];
    logic [NUM_WAYS-1:0][NUM_BANKS-1:0] wbuf_sel;
    logic [NUM_WAYS-1:0][NUM_BANKS-1:0] refill_sel;
    logic [BANK_W-1:0]                  req_bank;

    assign req_bank = req.offset[OFFSET_W-1:2];

    // a store miss lands its bytes on top of the returned word
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (req.op && req_bank == BANK_W'(b) && req.wstrb[i]) begin
                    fill_word[b][8*i +: 8] = req.wdata[8*i +: 8];
                end else begin
                    fill_word[b][8*i +: 8] = refill_word[8*i +: 8];
                end
            end
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
            logic [STRB_W-1:0]  be;
            logic [WORD_W-1:0]  wmask;
            logic [WORD_W-1:0]  wword;
            logic [INDEX_W-1:0] ram_addr;

            assign wbuf_sel[w][b]   = wbuf_we && wbuf.way == WAY_W'(w) && wbuf.bank == BANK_W'(b);
            assign refill_sel[w][b] = refill_we && refill_way == WAY_W'(w)
                                      && refill_bank == BANK_W'(b);

            assign be       = wbuf_sel[w][b] ? wbuf.wstrb : {STRB_W{refill_sel[w][b]}};
            assign wword    = wbuf_sel[w][b] ? wbuf.wdata : fill_word[b];
            assign ram_addr = wbuf_sel[w][b] ? wbuf.index : addr;   // buffered store owns the port

            for (genvar i = 0; i < STRB_W; i++) begin : g_byte
                assign wmask[8*i +: 8] = {8{be[i]}};
            end

            sram_sp #(.entry_t(logic [WORD_W-1:0])) i_bank_ram (
                .clk   (clk),
                .en    (rd_en || (|be)),
                .we    (wmask),
                .addr  (ram_addr),
                .wdata (wword),
                .rdata (bank_rdata[w][b])
            );

            assign victim_line[b*WORD_W +: WORD_W] = bank_rdata[victim_way][b];
        end
    end

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_way[w]) begin
                hit_word = hit_word | bank_rdata[w][req_bank];
            end
        end
    end

    // buffered stores drain before any refill can start
    a_no_bank_clash : assert property (@(posedge clk)
        wbuf_we && refill_we |-> (wbuf_sel & refill_sel) == '0);

endmodule

// ==== rtl/meta_array.sv ====
`timescale 1ns/1ps

module meta_array (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic [cache_pkg::INDEX_W-1:0]  index,
    input  logic                           set_dirty,
    input  logic [cache_pkg::WAY_W-1:0]    dirty_way,
    input  logic [cache_pkg::INDEX_W-1:0]  dirty_index,
    input  logic                           refill_done,
    input  logic                           refill_dirty,
    input  logic                           hit_update,
    input  logic [cache_pkg::NUM_WAYS-1:0] hit_way,
    output logic                           victim_dirty,
    output logic [cache_pkg::WAY_W-1:0]    replace_way
);
    import cache_pkg::*;

    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty;
    logic [NUM_SETS-1:0][WAY_W-1:0]    repl;   // way to evict next

    assign replace_way  = repl[index];
    assign victim_dirty = dirty[replace_way][index];   // dirty implies valid

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty <= '0;
            repl  <= '0;
        end else begin
            if (set_dirty) begin
                dirty[dirty_way][dirty_index] <= 1'b1;
            end
            if (refill_done) begin
                dirty[replace_way][index] <= refill_dirty;
            end

            if (hit_update) begin
                repl[index] <= hit_way[0];   // point away from the way just hit
            end else if (refill_done) begin
                repl[index] <= ~repl[index];
            end
        end
    end

endmodule

// ==== rtl/sram_sp.sv ====
`timescale 1ns/1ps

module sram_sp #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = cache_pkg::NUM_SETS
) (
    input  logic                       clk,
    input  logic                       en,
    input  logic [$bits(entry_t)-1:0]  we,     // per-bit write mask
    input  logic [$clog2(DEPTH)-1:0]   addr,
    input  entry_t                     wdata,
    output entry_t                     rdata
);

    entry_t mem [DEPTH];
    entry_t merged;

    assign merged = entry_t'((mem[addr] & ~we) | (wdata & we));

    always_ff @(posedge clk) begin
        if (en) begin
            if (|we) begin
                mem[addr] <= merged;
            end
            rdata <= merged;   // write-first
        end
    end

endmodule

// ==== rtl/tagv_array.sv ====
`timescale 1ns/1ps

module tagv_array (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic [cache_pkg::INDEX_W-1:0]  addr,
    input  logic                           rd_en,
    input  logic [cache_pkg::NUM_WAYS-1:0] we,
    input  logic [cache_pkg::TAG_W-1:0]    wtag,
    input  logic [cache_pkg::TAG_W-1:0]    cmp_tag,
    input  logic [cache_pkg::WAY_W-1:0]    victim_way,
    output logic [cache_pkg::NUM_WAYS-1:0] hit_way,
    output logic [cache_pkg::TAG_W-1:0]    victim_tag
);
    import cache_pkg::*;

    tagv_t                               rd_entry [NUM_WAYS];
    tagv_t                               wr_entry;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0]   valid_bits;   // ram contents survive reset
    logic [NUM_WAYS-1:0]                 valid_q;      // aligned with ram read data

    assign wr_entry = '{tag: wtag, valid: 1'b1};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            valid_q    <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (we[w]) begin
                    valid_bits[w][addr] <= 1'b1;
                end
                if (rd_en || we[w]) begin
                    valid_q[w] <= we[w] || valid_bits[w][addr];
                end
            end
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        sram_sp #(.entry_t(tagv_t)) i_tagv_ram (
            .clk   (clk),
            .en    (rd_en || we[w]),
            .we    ({$bits(tagv_t){we[w]}}),
            .addr  (addr),
            .wdata (wr_entry),
            .rdata (rd_entry[w])
        );

        assign hit_way[w] = valid_q[w] && rd_entry[w].valid && (rd_entry[w].tag == cmp_tag);
    end

    assign victim_tag = rd_entry[victim_way].tag;   // write-back address

    // a refill never installs a tag the other way already holds
    a_hit_onehot : assert property (@(posedge clk) disable iff (!resetn) $onehot0(hit_way));

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] SEED = 32'd50308
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          rd_req,
    input  cache_pkg::mem_rd_req_t        rd_line,
    output logic                          rd_rdy,
    output logic                          ret_valid,
    output logic                          ret_last,
    output logic [cache_pkg::WORD_W-1:0]  ret_data,
    input  logic                          wr_req,
    input  cache_pkg::mem_wr_req_t        wr_line,
    output logic                          wr_rdy
);
    import cache_pkg::*;

    logic [7:0]  mem_bytes [logic [31:0]];   // only written-back bytes live here
    logic [31:0] rand_state;

    // initial memory image, every address bit matters
    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ ~addr;
    endfunction

    function logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {16'h0000, rand_state[31:16]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] word;
        word = fill_pattern(addr);
        for (int i = 0; i < STRB_W; i++) begin
            if (mem_bytes.exists(addr + i)) begin
                word[8*i +: 8] = mem_bytes[addr + i];
            end
        end
        return word;
    endfunction

    task automatic write_line(input mem_wr_req_t line);
        for (int i = 0; i < LINE_W / 8; i++) begin
            mem_bytes[line.addr + i] = line.data[8*i +: 8];   // bank 0 lowest
        end
    endtask

    initial begin
        logic        rst_seen;
        logic        rd_seen;
        logic        wr_seen;
        logic        rd_fire;
        logic        wr_fire;
        logic [31:0] rd_addr;
        int          beat;      // next beat to return, -1 when no burst
        int          rd_wait;
        int          wr_wait;
        rand_state = SEED;
        rd_rdy     = 1'b0;
        wr_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        ret_data   = '0;
        rd_addr    = '0;
        beat       = -1;
        rd_wait    = 0;
        wr_wait    = 0;
        forever begin
            @(negedge clk);
            rst_seen = !resetn;
            rd_seen  = rd_req;
            wr_seen  = wr_req;
            rd_fire  = rd_req && rd_rdy;   // transfer on the coming edge
            wr_fire  = wr_req && wr_rdy;
            if (wr_fire) begin
                write_line(wr_line);
            end
            if (rd_fire) begin
                rd_addr = rd_line.addr;
            end
            @(posedge clk);
            #1;
            if (rst_seen) begin
                rd_rdy    = 1'b0;
                wr_rdy    = 1'b0;
                ret_valid = 1'b0;
                ret_last  = 1'b0;
                beat      = -1;
            end else begin
                if (wr_fire) begin
                    wr_rdy  = 1'b0;
                    wr_wait = int'(next_rand() % 4);
                end else if (wr_seen && !wr_rdy) begin
                    if (wr_wait == 0) begin
                        wr_rdy = 1'b1;
                    end else begin
                        wr_wait--;
                    end
                end

                if (rd_fire) begin
                    rd_rdy  = 1'b0;
                    rd_wait = int'(next_rand() % 4);
                    beat    = 0;
                end else if (rd_seen && !rd_rdy) begin
                    if (rd_wait == 0) begin
                        rd_rdy = 1'b1;
                    end else begin
                        rd_wait--;
                    end
                end

                // burst beats, now and then a bubble
                if (beat >= 0 && next_rand() % 4 != 0) begin
                    ret_valid = 1'b1;
                    ret_data  = read_word(rd_addr + 4 * beat);
                    ret_last  = beat == NUM_BANKS - 1;
                    beat      = (beat == NUM_BANKS - 1) ? -1 : beat + 1;
                end else begin
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

// ==== verif/tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;
    import cache_pkg::*;

    localparam int          NUM_REQS   = 2000;
    localparam int          WAIT_LIMIT = 200;   // cycles
    localparam logic [31:0] SEED       = 32'd50308;

    // three tags over two ways, so sets keep evicting
    localparam logic [TAG_W-1:0]   TAG_POOL [3]   = '{20'h00001, 20'h00002, 20'h00003};
    localparam logic [INDEX_W-1:0] INDEX_POOL [4] = '{8'h00, 8'h01, 8'h80, 8'hff};

    typedef struct packed {
        cpu_req_t    req;
        logic [31:0] cycle;   // negedge count at acceptance
        logic        hot;     // line known present, must hit
    } pend_t;

    logic              clk;
    logic              resetn;
    logic              valid;
    cpu_req_t          req;
    logic              addr_ok;
    logic              data_ok;
    logic [WORD_W-1:0] rdata;
    logic              rd_req;
    mem_rd_req_t       rd_line;
    logic              rd_rdy;
    logic              ret_valid;
    logic              ret_last;
    logic [WORD_W-1:0] ret_data;
    logic              wr_req;
    mem_wr_req_t       wr_line;
    logic              wr_rdy;

    logic [31:0] rand_state;
    logic [31:0] shadow [logic [31:0]];        // cpu view, word address keyed
    logic        stored_line [logic [31:0]];   // lines stored to since last write-back
    pend_t       pending [$];
    cpu_req_t    last_req;
    logic        have_last    = 1'b0;
    int          cycle        = 0;
    int          accept_count = 0;
    int          done_count   = 0;

    cache_top i_cache_top (.*);

    mem_model #(.SEED(SEED)) i_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic mismatch_found(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic protocol_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        abort_run();
    endtask

    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ ~addr;
    endfunction

    function logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {16'h0000, rand_state[31:16]};
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return fill_pattern(addr);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input cpu_req_t r);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < STRB_W; i++) begin
            if (r.wstrb[i]) begin
                res[8*i +: 8] = r.wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic cpu_req_t build_req(input cpu_req_t prev, input logic have_prev);
        cpu_req_t    r;
        logic [31:0] pick;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [1:0]  bank;
        pick = next_rand();
        bank = pick[5:4];
        if (have_prev && pick[1:0] == 2'd0) begin
            r.tag   = prev.tag;   // same line again
            r.index = prev.index;
            if (pick[2]) begin
                bank = prev.offset[3:2];   // store then read of one word
            end
        end else begin
            r.tag   = TAG_POOL[next_rand() % 3];
            r.index = INDEX_POOL[next_rand() % 4];
        end
        hi       = next_rand();
        lo       = next_rand();
        r.op     = pick[3];
        r.offset = {bank, 2'b00};
        r.wstrb  = (pick[9:6] == 4'h0) ? 4'hf : pick[9:6];
        r.wdata  = {hi[15:0], lo[15:0]};
        return r;
    endfunction

    initial begin
        cpu_req_t r;
        cpu_req_t prev;
        logic     have_prev;
        logic     taken;
        int       waited;
        rand_state = SEED;
        resetn     = 1'b0;
        valid      = 1'b0;
        req        = '0;
        prev       = '0;
        have_prev  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int n = 0; n < NUM_REQS; n++) begin
            r = build_req(prev, have_prev);
            if (next_rand() % 8 == 0) begin
                valid = 1'b0;   // idle cycle
                @(posedge clk);
                #1;
            end
            valid  = 1'b1;
            req    = r;
            taken  = 1'b0;
            waited = 0;
            while (!taken) begin
                @(negedge clk);
                taken = addr_ok;
                @(posedge clk);
                #1;
                waited++;
                if (!taken && waited > WAIT_LIMIT) begin
                    protocol_error("request was never accepted, addr_ok stayed low");
                end
            end
            prev      = r;
            have_prev = 1'b1;
        end
        valid = 1'b0;

        waited = 0;
        while (pending.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                protocol_error("accepted requests never received data_ok");
            end
        end

        if (accept_count == NUM_REQS && done_count == NUM_REQS) begin
            $display("** PASS **");
            $finish;
        end else begin
            protocol_error("count of data_ok pulses differs from accepted requests");
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        pend_t       p;
        logic [31:0] addr;
        logic [31:0] line;
        logic [31:0] exp;
        if (resetn) begin
            if (data_ok) begin
                assert (pending.size() != 0)
                    else protocol_error("data_ok came without an outstanding request");
                p    = pending.pop_front();
                addr = {p.req.tag, p.req.index, p.req.offset};
                done_count++;
                if (p.req.op) begin
                    shadow[addr] = merge_bytes(shadow_word(addr), p.req);
                    stored_line[{addr[31:OFFSET_W], {OFFSET_W{1'b0}}}] = 1'b1;
                end else begin
                    exp = shadow_word(addr);
                    assert (rdata == exp)
                        else mismatch_found($sformatf("read of %h returned %h, expected %h",
                                                      addr, rdata, exp));
                    if (p.hot) begin
                        assert (cycle == p.cycle + 1)
                            else mismatch_found($sformatf("read of %h took %0d cycles, expected 1",
                                                          addr, cycle - p.cycle));
                    end
                end
            end

            if (valid && addr_ok) begin
                p.req   = req;
                p.cycle = cycle;
                p.hot   = !req.op && have_last && req.tag == last_req.tag
                          && req.index == last_req.index && pending.size() == 0;
                pending.push_back(p);
                last_req  = req;
                have_last = 1'b1;
                accept_count++;
            end

            // the refill always belongs to the newest request
            if (rd_req) begin
                assert (rd_line.addr == {last_req.tag, last_req.index, {OFFSET_W{1'b0}}})
                    else mismatch_found($sformatf("rd_line %h, expected line of tag %h index %h",
                                                  rd_line.addr, last_req.tag, last_req.index));
            end

            if (wr_req && wr_rdy) begin
                line = wr_line.addr;
                assert (stored_line.exists(line))
                    else protocol_error($sformatf("write-back of line %h that holds no store",
                                                  line));
                stored_line.delete(line);
                for (int b = 0; b < NUM_BANKS; b++) begin
                    exp = shadow_word(line + 4 * b);
                    assert (wr_line.data[b*WORD_W +: WORD_W] == exp)
                        else mismatch_found($sformatf("write-back word %h is %h, expected %h",
                                                      line + 4 * b,
                                                      wr_line.data[b*WORD_W +: WORD_W], exp));
                end
            end
            cycle++;
        end
    end

    a_quiet_after_reset : assert property (@(posedge clk)
        $rose(resetn) |-> !data_ok && !rd_req && !wr_req)
        else protocol_error("data_ok, rd_req or wr_req was high right after reset");

    a_single_mem_req : assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else protocol_error("rd_req and wr_req were high in the same cycle");

endmodule
